/* project.f */
verilog/sprite_pkg.sv
verilog/video_timing.sv
verilog/sprite_attr_ram.sv
verilog/sprite_bitmap_rom.sv
verilog/scanline_buffer.sv
verilog/sprite_scanline_renderer.sv
verilog/sprite_video_top.sv
verif/sprite_video_tb.sv

/* verif/sprite_video_tb.sv */
module sprite_video_tb;

  logic                     clk;
  logic                     arst_n;
  logic                     cpu_we;
  logic [5:0]               cpu_addr;
  sprite_pkg::sprite_word_u cpu_wdata;
  logic                     hsync;
  logic                     vsync;
  logic                     display_on;
  logic [8:0]               hpos;
  logic [8:0]               vpos;
  logic [3:0]               rgb;
  logic                     ram_busy;

  // shadow of the sprite ram, and the copy taken on the load line
  logic [7:0] sh_x [32];
  logic [7:0] sh_y [32];
  logic [7:0] sh_a [32];
  logic [7:0] snap_x [32];
  logic [7:0] snap_y [32];
  logic [7:0] snap_a [32];
  logic       snap_valid = 1'b0;   // no table in the renderer before the first copy

  logic [3:0] exp_line [256];      // expected pixels of the line on display
  logic [3:0] exp_pix;
  logic [8:0] prev_h = 9'd0;       // rgb belongs to the position one cycle back
  logic [8:0] prev_v = 9'd0;
  logic       clk_seen = 1'b0;
  logic       tb_live = 1'b0;      // high from the second edge after reset
  int         pixel_errs = 0;
  int         timing_errs = 0;
  int         other_errs = 0;
  int         lit_pixels = 0;      // nonzero pixels the model expected

  sprite_video_top dut0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .cpu_we     (cpu_we),
    .cpu_addr   (cpu_addr),
    .cpu_wdata  (cpu_wdata),
    .hsync      (hsync),
    .vsync      (vsync),
    .display_on (display_on),
    .hpos       (hpos),
    .vpos       (vpos),
    .rgb        (rgb),
    .ram_busy   (ram_busy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    prev_h   <= hpos;
    prev_v   <= vpos;
    clk_seen <= 1'b1;
    tb_live  <= arst_n;
  end

  assign exp_pix = exp_line[prev_h[7:0]];

  // row r of bitmap b: b, r, then both inverted
  function automatic logic [15:0] rom_row(input logic [3:0] b, input logic [3:0] r);
    return {b, r, ~b, ~r};
  endfunction

  // colour of pixel (x, y), painted while line y-1 was selected
  function automatic logic [3:0] ref_pixel(input int x, input int y);
    int          s;
    int          row;
    int          ofs;
    int          used;
    logic [3:0]  colour;
    logic [15:0] bits;
    colour = 4'd0;
    used   = 0;
    if (!snap_valid || y < 1 || y >= 240) begin
      return 4'd0;   // line 0 follows a line with no painting
    end
    for (s = 0; s < 32; s++) begin
      row = (y - 1 - int'(snap_y[s]) + 256) % 256;
      if (row < 16 && used < 8) begin
        used++;   // slot order is index order
        ofs  = (x - int'(snap_x[s]) + 256) % 256;
        bits = rom_row(snap_a[s][7:4], 4'(row));
        if (ofs < 16 && bits[ofs]) begin
          colour = snap_a[s][3:0];   // later slot wins
        end
      end
    end
    return colour;
  endfunction

  // at the start of each line: table snapshot on the load line, then the expected pixels
  always @(negedge clk) begin : line_model
    int x;
    if (hpos == 9'd0) begin
      if (vpos == sprite_pkg::load_line) begin
        snap_x     = sh_x;
        snap_y     = sh_y;
        snap_a     = sh_a;
        snap_valid = 1'b1;
      end
      for (x = 0; x < 256; x++) begin
        exp_line[x] = ref_pixel(x, vpos);
        if (exp_line[x] != 4'd0) lit_pixels++;
      end
    end
  end

  a_reset_quiet: assert property (
    @(posedge clk) (clk_seen && !tb_live) |-> (rgb == 4'd0 && !ram_busy && !hsync && !vsync)
  ) else begin
    timing_errs++;
    $display("Mismatch at %0t: reset outputs rgb %0d ram_busy %b hsync %b vsync %b", $time,
             $sampled(rgb), $sampled(ram_busy), $sampled(hsync), $sampled(vsync));
  end

  a_timing: assert property (
    @(posedge clk)
    tb_live |->
    (hsync == (hpos >= sprite_pkg::h_sync_start && hpos < sprite_pkg::h_sync_end)) &&
    (vsync == (vpos >= sprite_pkg::v_sync_start && vpos < sprite_pkg::v_sync_end)) &&
    (display_on == (hpos < sprite_pkg::h_active && vpos < sprite_pkg::v_active)) &&
    (ram_busy == (vpos == sprite_pkg::load_line && hpos < sprite_pkg::load_end)) &&
    (vpos < sprite_pkg::v_total)
  ) else begin
    timing_errs++;
    $display("Mismatch at %0t: at (%0d,%0d) hsync %b vsync %b display_on %b ram_busy %b",
             $time, $sampled(hpos), $sampled(vpos), $sampled(hsync), $sampled(vsync),
             $sampled(display_on), $sampled(ram_busy));
  end

  a_frame_wrap: assert property (
    @(posedge clk) disable iff (!tb_live)
    (hpos == sprite_pkg::h_total - 1 && vpos == sprite_pkg::v_total - 1) |=>
    (hpos == 9'd0 && vpos == 9'd0)
  ) else begin
    timing_errs++;
    $display("Mismatch at %0t: frame did not wrap to line 0", $time);
  end

  a_pixel: assert property (
    @(posedge clk) disable iff (!tb_live)
    (prev_v < sprite_pkg::v_active && prev_h < sprite_pkg::h_active) |-> (rgb == exp_pix)
  ) else begin
    pixel_errs++;
    $display("Mismatch at %0t: pixel (%0d,%0d) rgb %0d expected %0d", $time,
             $sampled(prev_h), $sampled(prev_v), $sampled(rgb), $sampled(exp_pix));
  end

  task automatic abort_run(input string what);
    other_errs++;
    $display("error at %0t: %s", $time, what);
    $display("errors: pixel %0d timing %0d other %0d", pixel_errs, timing_errs, other_errs);
    $display(">>> FAIL");
    $finish;
  endtask

  // returns 2 units after the edge that starts cycle (h, v)
  task automatic wait_pos(input int v, input int h);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      #2;
      n++;
    end while (!(vpos == v && hpos == h) && n < sprite_pkg::h_total * sprite_pkg::v_total + 16);
    if (!(vpos == v && hpos == h)) begin
      abort_run($sformatf("timed out waiting for line %0d hpos %0d", v, h));
    end
  endtask

  // called 2 units after an edge, the write lands at the next edge unless ram_busy
  task automatic cpu_write(input logic [5:0] addr, input sprite_pkg::sprite_word_u data);
    cpu_we    = 1'b1;
    cpu_addr  = addr;
    cpu_wdata = data;
    if (!ram_busy) begin
      if (addr[0]) begin
        sh_a[addr[5:1]] = data.attr.attr;
      end else begin
        sh_x[addr[5:1]] = data.pos.xpos;
        sh_y[addr[5:1]] = data.pos.ypos;
      end
    end
    @(posedge clk);
    #2;
    cpu_we = 1'b0;
  endtask

  task automatic put_sprite(input int s, input logic [7:0] x, input logic [7:0] y,
                            input logic [3:0] bmp, input logic [3:0] col);
    sprite_pkg::sprite_word_u w;
    w          = '0;
    w.pos.xpos = x;
    w.pos.ypos = y;
    cpu_write(6'(2 * s), w);
    w           = '0;
    w.attr.attr = {bmp, col};
    cpu_write(6'(2 * s + 1), w);
  endtask

  initial begin : stimulus
    int s;
    void'($urandom(82));
    arst_n    = 1'b0;
    cpu_we    = 1'b0;
    cpu_addr  = 6'd0;
    cpu_wdata = '0;
    repeat (8) @(posedge clk);
    #2;
    arst_n = 1'b1;

    // every ram word defined, sprites parked on line 240 where no visible line picks them
    for (s = 0; s < 32; s++) begin
      put_sprite(s, 8'(8 * s), 8'd240, 4'(s), 4'(s % 15 + 1));
    end
    put_sprite(3, 8'd40, 8'd50, 4'hb, 4'd5);   // lone sprite, shows from line 51
    wait_pos(sprite_pkg::load_line, 0);
    wait_pos(sprite_pkg::v_active, 0);         // that frame fully shown

    // ten sprites over lines 98 to 115, x overlaps, sprite 0 wraps past x 255
    put_sprite(0, 8'd250, 8'd100, 4'd15, 4'd1);
    for (s = 1; s < 10; s++) begin
      put_sprite(s, 8'(10 * s + 20), 8'(100 - s % 3), 4'(15 - s), 4'(s + 1));
    end
    wait_pos(sprite_pkg::load_line, 10);
    cpu_write(6'd40, 16'h7880);   // sprite 20 to the middle, dropped while busy
    wait_pos(sprite_pkg::v_active, 0);

    // all 32 sprites random
    for (s = 0; s < 32; s++) begin
      put_sprite(s, 8'($urandom), 8'($urandom), 4'($urandom), 4'($urandom));
    end
    wait_pos(sprite_pkg::load_line, 0);
    wait_pos(sprite_pkg::v_active, 0);

    if (lit_pixels == 0) begin
      other_errs++;
      $display("error: the model never expected a sprite pixel on screen");
    end
    $display("errors: pixel %0d timing %0d other %0d", pixel_errs, timing_errs, other_errs);
    if (pixel_errs + timing_errs + other_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* verilog/scanline_buffer.sv */
module scanline_buffer (
  input  logic                clk,
  input  logic [8:0]          hpos,
  input  logic [8:0]          vpos,
  input  sprite_pkg::pix_wr_t pix_wr,
  output logic [3:0]          rgb
);

  // two 256-pixel halves, vpos[0] picks the half on display
  logic [3:0] mem [512];
  logic [8:0] rd_idx;

  assign rd_idx = {vpos[0], hpos[7:0]};

  // buffer powers up blank
  initial begin
    for (int n = 0; n < 512; n++) begin
      mem[n] = 4'd0;
    end
    rgb = 4'd0;
  end

  always @(posedge clk) begin
    rgb         <= mem[rd_idx];
    mem[rd_idx] <= 4'd0;          // read and clear, ready for the renderer
    if (pix_wr.we) begin
      mem[pix_wr.addr] <= pix_wr.colour;  // other half, never rd_idx
    end
  end

  // renderer stays on the half that is not being shown
  a_half_split: assert property (
    @(posedge clk)
    pix_wr.we |-> (pix_wr.addr[8] != vpos[0])
  );

endmodule

/* verilog/sprite_attr_ram.sv */
module sprite_attr_ram (
  input  logic                     clk,
  input  logic                     cpu_we,
  input  logic [5:0]               cpu_addr,   // {sprite, word}
  input  sprite_pkg::sprite_word_u cpu_wdata,
  input  logic [5:0]               rd_addr,
  input  logic                     busy,       // renderer owns the array
  output sprite_pkg::sprite_word_u rdata
);

  // two words per sprite, even = position, odd = attribute
  sprite_pkg::sprite_word_u mem [2 * sprite_pkg::n_sprites];

  always_ff @(posedge clk) begin
    if (busy) begin
      // renderer read, data valid one cycle later
      rdata <= mem[rd_addr];
    end else if (cpu_we) begin
      mem[cpu_addr] <= cpu_wdata;  // cpu only gets in while idle
    end
  end

endmodule

/* verilog/sprite_bitmap_rom.sv */
module sprite_bitmap_rom (
  input  logic [7:0]  addr,   // {bitmap, row}
  output logic [15:0] data
);

  logic [15:0] mem [256];

  // each row carries its own bitmap and row number, plus the inverses
  initial begin
    for (int b = 0; b < 16; b++) begin
      for (int r = 0; r < 16; r++) begin
        mem[b * 16 + r] = {4'(b), 4'(r), ~4'(b), ~4'(r)};
      end
    end
  end

  assign data = mem[addr];   // no read latency

endmodule

/* verilog/sprite_pkg.sv */
package sprite_pkg;

  // video timing, in pixel clocks and lines
  localparam int unsigned h_total      = 320;
  localparam int unsigned h_active     = 256;
  localparam int unsigned h_sync_start = 280;
  localparam int unsigned h_sync_end   = 296;  // first count after the pulse
  localparam int unsigned v_total      = 262;
  localparam int unsigned v_active     = 240;
  localparam int unsigned v_sync_start = 245;
  localparam int unsigned v_sync_end   = 248;
  localparam int unsigned load_line    = 260;  // table copy happens in vertical blank

  // sprite counts and the per-line schedule
  localparam int unsigned n_sprites_log2 = 5;
  localparam int unsigned n_sprites      = 1 << n_sprites_log2;
  localparam int unsigned m_slots_log2   = 3;
  localparam int unsigned m_slots        = 1 << m_slots_log2;
  localparam int unsigned select_end     = 2 * n_sprites;               // 2 cycles per sprite
  localparam int unsigned render_end     = select_end + 18 * m_slots;   // 2 fetch + 16 shift
  localparam int unsigned load_end       = 2 * n_sprites + 8;           // copy window on line 260

  // even ram word: position
  typedef struct packed {
    logic [7:0] ypos;
    logic [7:0] xpos;
  } sprite_pos_t;

  // odd ram word: attribute, bitmap index in [7:4] and colour in [3:0]
  typedef struct packed {
    logic [7:0] spare;
    logic [7:0] attr;
  } sprite_attr_t;

  typedef union packed {
    sprite_pos_t  pos;
    sprite_attr_t attr;
  } sprite_word_u;

  // one entry of the renderer's copy of the table
  typedef struct packed {
    logic [7:0] xpos;
    logic [7:0] ypos;
    logic [7:0] attr;
  } sprite_rec_t;

  // a sprite picked for the current line
  typedef struct packed {
    logic       active;
    logic [7:0] xpos;
    logic [3:0] yofs;    // row within the bitmap
    logic [3:0] bitmap;
    logic [3:0] colour;
    logic [7:0] spare;
  } line_slot_t;

  // one pixel write into the line buffer, addr[8] picks the half
  typedef struct packed {
    logic       we;
    logic [8:0] addr;
    logic [3:0] colour;
  } pix_wr_t;

endpackage

/* verilog/sprite_scanline_renderer.sv */
module sprite_scanline_renderer (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic [8:0]               hpos,
  input  logic [8:0]               vpos,
  output logic [5:0]               ram_rd_addr,
  output logic                     ram_busy,
  input  sprite_pkg::sprite_word_u ram_rdata,
  output logic [7:0]               rom_addr,
  input  logic [15:0]              rom_data,
  output sprite_pkg::pix_wr_t      pix_wr
);

  // private copy of the sprite table, loaded once per frame
  sprite_pkg::sprite_rec_t tbl [sprite_pkg::n_sprites];
  logic                    tbl_valid;  // set after the first copy

  // sprites picked for this line
  sprite_pkg::line_slot_t slot [sprite_pkg::m_slots];

  logic [sprite_pkg::m_slots_log2:0] j;  // slots filled so far
  logic [sprite_pkg::m_slots_log2:0] k;  // slot being painted

  logic [7:0]  z;            // line minus ypos
  logic        romload;      // second fetch cycle
  logic [15:0] out_bitmap;   // row being shifted out, lsb first
  logic [8:0]  wr_ofs;       // {half, x}
  logic [3:0]  out_colour;

  logic                                  sel_phase;
  logic                                  paint_phase;
  logic [sprite_pkg::n_sprites_log2-1:0] sel_idx;
  sprite_pkg::sprite_rec_t               sel_rec;
  sprite_pkg::line_slot_t                cur_slot;
  logic [5:0]                            cap_addr;
  logic [sprite_pkg::m_slots-1:0]        slot_act;   // one active flag per slot

  // ram word index for copy count n, counts past the table go back to sprite 0
  function automatic logic [5:0] copy_addr(input logic [6:0] n);
    logic [4:0] s;
    s = (n < 7'(sprite_pkg::select_end)) ? n[5:1] : 5'd0;
    return {s, n[0]};
  endfunction

  // copy window, cpu is locked out
  assign ram_busy = (vpos == sprite_pkg::load_line) && (hpos < sprite_pkg::load_end);

  assign sel_phase   = !vpos[8] && (hpos < sprite_pkg::select_end);
  assign paint_phase = !vpos[8] && (hpos >= sprite_pkg::select_end) &&
                       (hpos < sprite_pkg::render_end);

  assign sel_idx  = hpos[sprite_pkg::n_sprites_log2:1];   // 2 cycles per sprite
  assign sel_rec  = tbl[sel_idx];
  assign cur_slot = slot[k[sprite_pkg::m_slots_log2-1:0]];

  // data now on ram_rdata was addressed two counts ago
  assign cap_addr = copy_addr(hpos[6:0] - 7'd2);

  always_ff @(posedge clk) begin
    if (ram_busy) begin
      ram_rd_addr <= copy_addr(hpos[6:0]);
    end
    if (ram_busy && (hpos >= 9'd2)) begin
      if (cap_addr[0]) begin
        tbl[cap_addr[5:1]].attr <= ram_rdata.attr.attr;   // odd word
      end else begin
        tbl[cap_addr[5:1]].xpos <= ram_rdata.pos.xpos;    // even word
        tbl[cap_addr[5:1]].ypos <= ram_rdata.pos.ypos;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tbl_valid <= 1'b0;
    end else if (ram_busy && (hpos == sprite_pkg::load_end - 1)) begin
      tbl_valid <= 1'b1;  // used from line 0 onwards
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      slot       <= '{default: '0};
      j          <= '0;
      k          <= '0;
      z          <= 8'd0;
      romload    <= 1'b0;
      out_bitmap <= 16'd0;
      wr_ofs     <= 9'd0;
      out_colour <= 4'd0;
      rom_addr   <= 8'd0;
    end else if (sel_phase) begin
      // paint state restarts for this line
      k          <= '0;
      romload    <= 1'b0;
      out_bitmap <= 16'd0;
      if (!hpos[0]) begin
        z <= vpos[7:0] - sel_rec.ypos;   // wraps mod 256
      end else if (tbl_valid && (z < 8'd16) && (j < sprite_pkg::m_slots)) begin
        slot[j[sprite_pkg::m_slots_log2-1:0]] <= '{
          active: 1'b1,
          xpos:   sel_rec.xpos,
          yofs:   z[3:0],
          bitmap: sel_rec.attr[7:4],
          colour: sel_rec.attr[3:0],
          spare:  8'd0
        };
        j <= j + 1'b1;    // lower index wins the earlier slot
      end
    end else begin
      j <= '0;
      if (paint_phase) begin
        if (out_bitmap == 16'd0) begin
          // shifter empty, fetch the next slot
          if (k < sprite_pkg::m_slots) begin
            if (!romload) begin
              rom_addr <= {cur_slot.bitmap, cur_slot.yofs};
            end else begin
              out_bitmap <= cur_slot.active ? rom_data : 16'd0;   // idle slot paints nothing
              wr_ofs     <= {~vpos[0], cur_slot.xpos};            // half shown next line
              out_colour <= cur_slot.colour;
              slot[k[sprite_pkg::m_slots_log2-1:0]].active <= 1'b0;
              k <= k + 1'b1;
            end
            romload <= !romload;
          end
        end else begin
          out_bitmap  <= out_bitmap >> 1;
          wr_ofs[7:0] <= wr_ofs[7:0] + 8'd1;   // x wraps, half kept
        end
      end
    end
  end

  // a set bit in the shifter means a pixel this cycle
  always_comb begin
    pix_wr.we     = paint_phase && out_bitmap[0];
    pix_wr.addr   = wr_ofs;
    pix_wr.colour = out_colour;
  end

  always_comb begin
    for (int n = 0; n < sprite_pkg::m_slots; n++) begin
      slot_act[n] = slot[n].active;
    end
  end

  // copy window opens at the start of the load line
  a_busy_line: assert property (
    @(posedge clk) disable iff (!arst_n)
    $rose(ram_busy) |-> (vpos == sprite_pkg::load_line) && (hpos == 9'd0)
  );

  // each selection owns exactly one slot when painting starts
  a_slot_limit: assert property (
    @(posedge clk) disable iff (!arst_n)
    (paint_phase && hpos == sprite_pkg::select_end) |-> (j == $countones(slot_act))
  );

  // all 8 slots fit inside the paint window
  a_paint_done: assert property (
    @(posedge clk) disable iff (!arst_n)
    (hpos == sprite_pkg::render_end) |-> (out_bitmap == 16'd0)
  );

endmodule

/* verilog/sprite_video_top.sv */
module sprite_video_top (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     cpu_we,
  input  logic [5:0]               cpu_addr,
  input  sprite_pkg::sprite_word_u cpu_wdata,
  output logic                     hsync,
  output logic                     vsync,
  output logic                     display_on,
  output logic [8:0]               hpos,
  output logic [8:0]               vpos,
  output logic [3:0]               rgb,
  output logic                     ram_busy
);

  logic [5:0]               ram_rd_addr;
  sprite_pkg::sprite_word_u ram_rdata;
  logic [7:0]               rom_addr;
  logic [15:0]              rom_data;
  sprite_pkg::pix_wr_t      pix_wr;

  video_timing timing0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .hpos       (hpos),
    .vpos       (vpos),
    .hsync      (hsync),
    .vsync      (vsync),
    .display_on (display_on)
  );

  // cpu writes land only while ram_busy is low
  sprite_attr_ram ram0 (
    .clk       (clk),
    .cpu_we    (cpu_we),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .rd_addr   (ram_rd_addr),
    .busy      (ram_busy),
    .rdata     (ram_rdata)
  );

  sprite_bitmap_rom rom0 (
    .addr (rom_addr),
    .data (rom_data)
  );

  sprite_scanline_renderer render0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .hpos        (hpos),
    .vpos        (vpos),
    .ram_rd_addr (ram_rd_addr),
    .ram_busy    (ram_busy),
    .ram_rdata   (ram_rdata),
    .rom_addr    (rom_addr),
    .rom_data    (rom_data),
    .pix_wr      (pix_wr)
  );

  scanline_buffer linebuf0 (
    .clk    (clk),
    .hpos   (hpos),
    .vpos   (vpos),
    .pix_wr (pix_wr),
    .rgb    (rgb)
  );

endmodule

/* verilog/video_timing.sv */
module video_timing (
  input  logic       clk,
  input  logic       arst_n,
  output logic [8:0] hpos,
  output logic [8:0] vpos,
  output logic       hsync,
  output logic       vsync,
  output logic       display_on
);

  logic [8:0] h_nxt;   // counter values after this edge
  logic [8:0] v_nxt;
  logic       h_wrap;

  assign h_wrap = (hpos == sprite_pkg::h_total - 1);

  always_comb begin
    h_nxt = h_wrap ? 9'd0 : hpos + 9'd1;
    v_nxt = vpos;
    if (h_wrap) begin
      // end of line, step the line counter
      v_nxt = (vpos == sprite_pkg::v_total - 1) ? 9'd0 : vpos + 9'd1;
    end
  end

  // syncs decoded from the next count so they line up with hpos/vpos
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hpos       <= 9'd0;
      vpos       <= 9'd0;
      hsync      <= 1'b0;
      vsync      <= 1'b0;
      display_on <= 1'b0;
    end else begin
      hpos       <= h_nxt;
      vpos       <= v_nxt;
      hsync      <= (h_nxt >= sprite_pkg::h_sync_start) &&
                    (h_nxt <  sprite_pkg::h_sync_end);
      vsync      <= (v_nxt >= sprite_pkg::v_sync_start) &&
                    (v_nxt <  sprite_pkg::v_sync_end);
      display_on <= (h_nxt < sprite_pkg::h_active) &&
                    (v_nxt < sprite_pkg::v_active);   // visible window
    end
  end

  // counter never reaches the line length
  a_hpos_range: assert property (
    @(posedge clk) disable iff (!arst_n)
    hpos < sprite_pkg::h_total
  );

endmodule
